//--- hw/arch_cfg.svh
`ifndef ARCH_CFG_SVH
`define ARCH_CFG_SVH

// Width of one machine word and of the accumulator data path.
`define ARCH_DATA_WIDTH 8

// Width of a RAM address, also the operand field of an instruction.
`define ARCH_ADDR_WIDTH 4

// Number of words in the RAM.
`define ARCH_RAM_DEPTH 16

`endif

//--- hw/arch_pkg.sv
`include "arch_cfg.svh"

package arch_pkg;

    // One machine word.
    typedef logic [`ARCH_DATA_WIDTH-1:0] data_t;

    // RAM address and program counter value.
    typedef logic [`ARCH_ADDR_WIDTH-1:0] addr_t;

    // Upper nibble of the instruction word; codes 11 to 13 act as NOP.
    typedef enum logic [`ARCH_DATA_WIDTH-`ARCH_ADDR_WIDTH-1:0] {
        NOP  = 4'd0,
        LDA  = 4'd1,
        ADD  = 4'd2,
        SUB  = 4'd3,
        STA  = 4'd4,
        LDI  = 4'd5,
        JMP  = 4'd6,
        JC   = 4'd7,
        JZ   = 4'd8,
        JN   = 4'd9,
        OUTM = 4'd10,
        OUT  = 4'd14,
        HLT  = 4'd15
    } opcode_e;

    // Status flags written by ADD and SUB.
    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
    } flags_t;

endpackage

//--- hw/ctrl_pkg.sv
package ctrl_pkg;

    // Operation selected for the ALU.
    typedef enum logic [1:0] {
        PASS_B = 2'd0,
        ADD    = 2'd1,
        SUB    = 2'd2
    } alu_op_e;

    // Sequencer states.
    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        EXECUTE = 2'd1,
        HALTED  = 2'd2
    } seq_state_e;

    // One cycle of datapath control.
    typedef struct packed {
        logic    mem_sel_pc;
        logic    load_ir;
        logic    inc_pc;
        logic    load_pc;
        logic    load_a_mem;
        logic    load_a_imm;
        logic    load_a_alu;
        logic    load_b;
        logic    load_flags;
        logic    mem_write;
        alu_op_e alu_op;
        logic    out_load;
        logic    out_from_a;
        logic    out_from_ram;
        logic    halt;
    } ctrl_word_t;

endpackage

//--- hw/alu.sv
`include "arch_cfg.svh"

module alu (
    input  arch_pkg::data_t   a_i,
    input  arch_pkg::data_t   b_i,
    input  ctrl_pkg::alu_op_e op_i,
    output arch_pkg::data_t   result_o,
    output arch_pkg::flags_t  flags_o
);

    // One extra bit holds the carry out or the borrow.
    logic [`ARCH_DATA_WIDTH:0] wide;
    logic                      carry;

    always_comb begin
        wide  = '0;
        carry = 1'b0;
        case (op_i)
            ctrl_pkg::ADD: begin
                wide  = {1'b0, a_i} + {1'b0, b_i};
                carry = wide[`ARCH_DATA_WIDTH];
            end
            ctrl_pkg::SUB: begin
                wide  = {1'b0, a_i} - {1'b0, b_i};
                // Carry means no borrow.
                carry = ~wide[`ARCH_DATA_WIDTH];
            end
            default: begin
                wide  = {1'b0, b_i};
                carry = 1'b0;
            end
        endcase
    end

    assign result_o = wide[`ARCH_DATA_WIDTH-1:0];

    always_comb begin
        flags_o.zero     = (result_o == '0);
        flags_o.carry    = carry;
        flags_o.negative = result_o[`ARCH_DATA_WIDTH-1];
    end

endmodule

//--- hw/control_unit.sv
`include "arch_cfg.svh"

module control_unit (
    input  logic                   clk,
    input  logic                   rst_i,
    input  arch_pkg::data_t        ir_i,
    input  arch_pkg::flags_t       flags_i,
    output ctrl_pkg::ctrl_word_t   ctrl_o
);

    ctrl_pkg::seq_state_e state_q;
    ctrl_pkg::seq_state_e state_d;
    arch_pkg::opcode_e    opcode;

    assign opcode = arch_pkg::opcode_e'(ir_i[`ARCH_DATA_WIDTH-1:`ARCH_ADDR_WIDTH]);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ctrl_pkg::FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ctrl_pkg::FETCH: begin
                state_d = ctrl_pkg::EXECUTE;
            end
            ctrl_pkg::EXECUTE: begin
                if (opcode == arch_pkg::HLT) begin
                    state_d = ctrl_pkg::HALTED;
                end else begin
                    state_d = ctrl_pkg::FETCH;
                end
            end
            // Only reset leaves this state.
            default: begin
                state_d = ctrl_pkg::HALTED;
            end
        endcase
    end

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = ctrl_pkg::PASS_B;
        case (state_q)
            ctrl_pkg::FETCH: begin
                ctrl_o.mem_sel_pc = 1'b1;
                ctrl_o.load_ir    = 1'b1;
                ctrl_o.inc_pc     = 1'b1;
            end
            ctrl_pkg::EXECUTE: begin
                case (opcode)
                    arch_pkg::LDA: begin
                        ctrl_o.load_a_mem = 1'b1;
                    end
                    arch_pkg::ADD: begin
                        ctrl_o.alu_op     = ctrl_pkg::ADD;
                        ctrl_o.load_b     = 1'b1;
                        ctrl_o.load_a_alu = 1'b1;
                        ctrl_o.load_flags = 1'b1;
                    end
                    arch_pkg::SUB: begin
                        ctrl_o.alu_op     = ctrl_pkg::SUB;
                        ctrl_o.load_b     = 1'b1;
                        ctrl_o.load_a_alu = 1'b1;
                        ctrl_o.load_flags = 1'b1;
                    end
                    arch_pkg::STA: begin
                        ctrl_o.mem_write = 1'b1;
                    end
                    arch_pkg::LDI: begin
                        ctrl_o.load_a_imm = 1'b1;
                    end
                    arch_pkg::JMP: begin
                        ctrl_o.load_pc = 1'b1;
                    end
                    arch_pkg::JC: begin
                        ctrl_o.load_pc = flags_i.carry;
                    end
                    arch_pkg::JZ: begin
                        ctrl_o.load_pc = flags_i.zero;
                    end
                    arch_pkg::JN: begin
                        ctrl_o.load_pc = flags_i.negative;
                    end
                    arch_pkg::OUT: begin
                        ctrl_o.out_load   = 1'b1;
                        ctrl_o.out_from_a = 1'b1;
                    end
                    arch_pkg::OUTM: begin
                        ctrl_o.out_load     = 1'b1;
                        ctrl_o.out_from_ram = 1'b1;
                    end
                    // NOP, HLT and the unused codes drive nothing here.
                    default: begin
                    end
                endcase
            end
            default: begin
                ctrl_o.halt = 1'b1;
            end
        endcase
    end

endmodule

//--- hw/cpu.sv
`include "arch_cfg.svh"

module cpu (
    input  logic             clk,
    input  logic             rst_i,
    output arch_pkg::addr_t  mem_addr_o,
    input  arch_pkg::data_t  mem_rdata_i,
    output logic             mem_we_o,
    output arch_pkg::data_t  mem_wdata_o,
    output logic             out_load_o,
    output logic             oe_a_o,
    output logic             oe_ram_o,
    output arch_pkg::data_t  a_o,
    output logic             halt_o,
    output arch_pkg::flags_t flags_o,
    output arch_pkg::data_t  debug_b_o,
    output arch_pkg::data_t  debug_ir_o,
    output arch_pkg::addr_t  debug_pc_o
);

    arch_pkg::data_t      a_q;
    arch_pkg::data_t      b_q;
    arch_pkg::data_t      ir_q;
    arch_pkg::addr_t      pc_q;
    arch_pkg::flags_t     flags_q;
    arch_pkg::addr_t      operand;
    arch_pkg::data_t      imm;
    arch_pkg::data_t      alu_result;
    arch_pkg::flags_t     alu_flags;
    ctrl_pkg::ctrl_word_t ctrl;

    assign operand = ir_q[`ARCH_ADDR_WIDTH-1:0];
    assign imm     = {{(`ARCH_DATA_WIDTH-`ARCH_ADDR_WIDTH){1'b0}}, operand};

    control_unit u_control_unit (
        .clk(clk),
        .rst_i(rst_i),
        .ir_i(ir_q),
        .flags_i(flags_q),
        .ctrl_o(ctrl)
    );

    // The operand word is read in the same cycle it is used, so B only mirrors it.
    alu u_alu (
        .a_i(a_q),
        .b_i(mem_rdata_i),
        .op_i(ctrl.alu_op),
        .result_o(alu_result),
        .flags_o(alu_flags)
    );

    assign mem_addr_o  = ctrl.mem_sel_pc ? pc_q : operand;
    assign mem_we_o    = ctrl.mem_write;
    assign mem_wdata_o = a_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            a_q     <= '0;
            b_q     <= '0;
            ir_q    <= '0;
            pc_q    <= '0;
            flags_q <= '0;
        end else begin
            if (ctrl.load_ir) begin
                ir_q <= mem_rdata_i;
            end
            if (ctrl.load_pc) begin
                pc_q <= operand;
            end else if (ctrl.inc_pc) begin
                pc_q <= pc_q + 1'b1;
            end
            if (ctrl.load_a_alu) begin
                a_q <= alu_result;
            end else if (ctrl.load_a_mem) begin
                a_q <= mem_rdata_i;
            end else if (ctrl.load_a_imm) begin
                a_q <= imm;
            end
            if (ctrl.load_b) begin
                b_q <= mem_rdata_i;
            end
            if (ctrl.load_flags) begin
                flags_q <= alu_flags;
            end
        end
    end

    assign out_load_o = ctrl.out_load;
    assign oe_a_o     = ctrl.out_from_a;
    assign oe_ram_o   = ctrl.out_from_ram;
    assign a_o        = a_q;
    assign halt_o     = ctrl.halt;

    assign flags_o    = flags_q;
    assign debug_b_o  = b_q;
    assign debug_ir_o = ir_q;
    assign debug_pc_o = pc_q;

endmodule

//--- hw/ram.sv
`include "arch_cfg.svh"

module ram (
    input  logic            clk,
    input  logic            we_i,
    input  arch_pkg::addr_t addr_i,
    input  arch_pkg::data_t wdata_i,
    input  logic            load_we_i,
    input  arch_pkg::addr_t load_addr_i,
    input  arch_pkg::data_t load_data_i,
    output arch_pkg::data_t rdata_o
);

    arch_pkg::data_t mem [`ARCH_RAM_DEPTH];

    // Program loading takes priority over a CPU store.
    always_ff @(posedge clk) begin
        if (load_we_i) begin
            mem[load_addr_i] <= load_data_i;
        end else if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    assign rdata_o = mem[addr_i];

endmodule

//--- hw/computer.sv
module computer (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             prog_we_i,
    input  arch_pkg::addr_t  prog_addr_i,
    input  arch_pkg::data_t  prog_data_i,
    output arch_pkg::data_t  out_data_o,
    output logic             out_strobe_o,
    output logic             halt_o,
    output arch_pkg::flags_t flags_o,
    output arch_pkg::data_t  debug_b_o,
    output arch_pkg::data_t  debug_ir_o,
    output arch_pkg::addr_t  debug_pc_o
);

    arch_pkg::addr_t cpu_mem_addr;
    arch_pkg::data_t cpu_mem_wdata;
    arch_pkg::data_t ram_rdata;
    logic            cpu_mem_we;
    logic            cpu_out_load;
    logic            cpu_oe_a;
    logic            cpu_oe_ram;
    arch_pkg::data_t cpu_a;
    arch_pkg::data_t out_src;

    cpu u_cpu (
        .clk(clk),
        .rst_i(rst_i),
        .mem_addr_o(cpu_mem_addr),
        .mem_rdata_i(ram_rdata),
        .mem_we_o(cpu_mem_we),
        .mem_wdata_o(cpu_mem_wdata),
        .out_load_o(cpu_out_load),
        .oe_a_o(cpu_oe_a),
        .oe_ram_o(cpu_oe_ram),
        .a_o(cpu_a),
        .halt_o(halt_o),
        .flags_o(flags_o),
        .debug_b_o(debug_b_o),
        .debug_ir_o(debug_ir_o),
        .debug_pc_o(debug_pc_o)
    );

    ram u_ram (
        .clk(clk),
        .we_i(cpu_mem_we),
        .addr_i(cpu_mem_addr),
        .wdata_i(cpu_mem_wdata),
        .load_we_i(prog_we_i),
        .load_addr_i(prog_addr_i),
        .load_data_i(prog_data_i),
        .rdata_o(ram_rdata)
    );

    // A has priority over the RAM word.
    assign out_src = cpu_oe_a   ? cpu_a     :
                     cpu_oe_ram ? ram_rdata :
                     '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_data_o   <= '0;
            out_strobe_o <= 1'b0;
        end else begin
            out_strobe_o <= cpu_out_load;
            if (cpu_out_load) begin
                out_data_o <= out_src;
            end
        end
    end

endmodule

//--- verification/computer_tb.sv
`include "arch_cfg.svh"

module computer_tb;

    logic             clk;
    logic             rst_i;
    logic             prog_we_i;
    arch_pkg::addr_t  prog_addr_i;
    arch_pkg::data_t  prog_data_i;
    arch_pkg::data_t  out_data_o;
    logic             out_strobe_o;
    logic             halt_o;
    arch_pkg::flags_t flags_o;
    arch_pkg::data_t  debug_b_o;
    arch_pkg::data_t  debug_ir_o;
    arch_pkg::addr_t  debug_pc_o;

    arch_pkg::data_t  prog_mem [`ARCH_RAM_DEPTH];
    arch_pkg::data_t  expected_q [$];
    arch_pkg::flags_t expected_flags;
    int               instr_count;
    int               run_index;

    computer dut0 (
        .clk(clk),
        .rst_i(rst_i),
        .prog_we_i(prog_we_i),
        .prog_addr_i(prog_addr_i),
        .prog_data_i(prog_data_i),
        .out_data_o(out_data_o),
        .out_strobe_o(out_strobe_o),
        .halt_o(halt_o),
        .flags_o(flags_o),
        .debug_b_o(debug_b_o),
        .debug_ir_o(debug_ir_o),
        .debug_pc_o(debug_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            abort_run($sformatf("FAIL t=%0t %s got %0h expected %0h",
                                $time, name, got, expected));
        end
    endtask

    // Unused words stay NOP.
    task automatic clear_program();
        for (int i = 0; i < `ARCH_RAM_DEPTH; i++) begin
            prog_mem[i] = '0;
        end
    endtask

    // Writes every RAM word under reset, then releases reset.
    task automatic load_program();
        @(posedge clk);
        rst_i <= 1'b1;
        for (int i = 0; i < `ARCH_RAM_DEPTH; i++) begin
            @(posedge clk);
            prog_we_i   <= 1'b1;
            prog_addr_i <= arch_pkg::addr_t'(i);
            prog_data_i <= prog_mem[i];
        end
        @(posedge clk);
        prog_we_i <= 1'b0;
        @(posedge clk);
        rst_i <= 1'b0;
    endtask

    task automatic run_program();
        int cycle;
        int limit;
        int after_halt;
        bit halted;
        cycle      = 0;
        after_halt = 0;
        halted     = 1'b0;
        limit      = 2 * instr_count + 20;
        load_program();
        // Cycle counts rising edges since the one that saw reset last.
        while (after_halt < 4) begin
            @(negedge clk);
            if (cycle <= 1) begin
                check_value("out_data_o", out_data_o, 0);
                check_value("out_strobe_o", out_strobe_o, 0);
                check_value("halt_o", halt_o, 0);
                check_value("flags_o", flags_o, 0);
                check_value("debug_b_o", debug_b_o, 0);
            end
            if (cycle == 0) begin
                check_value("debug_ir_o", debug_ir_o, 0);
                check_value("debug_pc_o", debug_pc_o, 0);
            end else if (cycle == 1) begin
                // First fetch has loaded word 0 and advanced the PC.
                check_value("debug_ir_o", debug_ir_o, prog_mem[0]);
                check_value("debug_pc_o", debug_pc_o, 1);
            end
            if (halted) begin
                assert (!out_strobe_o) else begin
                    abort_run($sformatf("Run %0d gave an output strobe after halt", run_index));
                end
                check_value("halt_o", halt_o, 1);
                after_halt++;
            end else if (halt_o) begin
                assert (cycle == 2 * instr_count) else begin
                    abort_run($sformatf("FAIL t=%0t halt_o rose at cycle %0d expected cycle %0d",
                                        $time, cycle, 2 * instr_count));
                end
                // The HLT word stays in IR once the sequencer stops.
                check_value("debug_ir_o", debug_ir_o[`ARCH_DATA_WIDTH-1:`ARCH_ADDR_WIDTH], 15);
                halted = 1'b1;
            end else if (cycle >= limit) begin
                abort_run($sformatf("Run %0d timed out, the CPU did not halt within %0d cycles",
                                    run_index, limit));
            end
            if (out_strobe_o) begin
                assert (expected_q.size() > 0) else begin
                    abort_run($sformatf("Run %0d produced more outputs than expected",
                                        run_index));
                end
                check_value("out_data_o", out_data_o, expected_q.pop_front());
            end
            @(posedge clk);
            cycle++;
        end
        assert (expected_q.size() == 0) else begin
            abort_run($sformatf("Run %0d halted with %0d expected outputs missing",
                                run_index, expected_q.size()));
        end
        check_value("flags_o", flags_o, expected_flags);
    endtask

    initial begin
        int               fd;
        int               code;
        int               addr;
        int               value;
        int               flag_z;
        int               flag_c;
        int               flag_n;
        logic [7:0]       kind;
        logic [8*128-1:0] line;
        bit               done;
        rst_i          = 1'b1;
        prog_we_i      = 1'b0;
        prog_addr_i    = '0;
        prog_data_i    = '0;
        expected_flags = '0;
        instr_count    = 0;
        run_index      = 1;
        done           = 1'b0;
        clear_program();
        repeat (2) @(posedge clk);
        fd = $fopen("verification/computer_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open verification/computer_golden.txt");
        end
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (kind)
                    "#": begin
                        code = $fgets(line, fd);
                    end
                    "P": begin
                        code = $fscanf(fd, " %h %h", addr, value);
                        prog_mem[addr] = arch_pkg::data_t'(value);
                    end
                    "O": begin
                        code = $fscanf(fd, " %h", value);
                        expected_q.push_back(arch_pkg::data_t'(value));
                    end
                    "F": begin
                        code = $fscanf(fd, " %d %d %d", flag_z, flag_c, flag_n);
                        expected_flags.zero     = flag_z[0];
                        expected_flags.carry    = flag_c[0];
                        expected_flags.negative = flag_n[0];
                    end
                    "C": begin
                        code = $fscanf(fd, " %d", instr_count);
                    end
                    "R": begin
                        run_program();
                        run_index++;
                        clear_program();
                    end
                    default: begin
                        abort_run($sformatf("Unknown record %c in the golden file", kind));
                    end
                endcase
            end
        end
        $fclose(fd);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hw
hw/arch_pkg.sv
hw/ctrl_pkg.sv
hw/alu.sv
hw/control_unit.sv
hw/cpu.sv
hw/ram.sv
hw/computer.sv
verification/computer_tb.sv

//--- verification/computer_golden.txt
# Records: P addr data | O value | F zero carry negative | C executed instructions | R run.
# P and O values are hex, F and C values are decimal.
P 0 1E
P 1 E0
P 2 57
P 3 E0
P 4 AF
P 5 E0
P 6 2F
P 7 4D
P 8 AD
P 9 1E
P A 2E
P B E0
P C F0
P E C8
P F 3A
O C8
O 07
O 3A
O 07
O 41
O 90
F 0 1 1
C 13
R
# Countdown loop with taken and fall-through branches.
P 0 1F
P 1 E0
P 2 3E
P 3 85
P 4 61
P 5 E0
P 6 99
P 7 79
P 9 3E
P A 9C
P C E0
P D F0
P E 01
P F 03
O 03
O 02
O 01
O 00
O FF
F 0 0 1
C 19
R
# Store, equal subtract and unused opcodes.
P 0 59
P 1 4F
P 2 3F
P 3 E0
P 4 AF
P 6 B0
P 7 F0
O 00
O 09
F 1 1 0
C 8
R
